/* Bender.yml */
package:
  name: id_decode

sources:
  - include_dirs:
      - include
    files:
      - design/loong_isa_pkg.sv
      - design/id_bus_pkg.sv
      - design/id_regfile.sv
      - design/id_inst_latch.sv
      - design/id_decoder.sv
      - design/id_hazard_unit.sv
      - design/id_resolve.sv
      - design/id_stage.sv
      - target: simulation
        files:
          - verif/id_stage_tb.sv

/* design/id_bus_pkg.sv */
`default_nettype none

`include "id_config.svh"

package id_bus_pkg;

    // IF -> ID
    typedef struct packed {
        logic [`ILEN-1:0] inst;
        logic [`XLEN-1:0] pc;
    } fetch_pkt_t;

    // ID -> IF redirect
    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } br_req_t;

    // result bus back from EX, MEM and WB
    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
        logic               not_ready;  // value still being produced, e.g. a load
    } fwd_t;

    // ID -> EX
    typedef struct packed {
        loong_isa_pkg::alu_op_e alu_op;
        loong_isa_pkg::mem_op_e mem_op;
        logic [`XLEN-1:0]       src1;
        logic [`XLEN-1:0]       src2;
        logic [`XLEN-1:0]       rkd_value;  // store data
        logic [`XLEN-1:0]       pc;
        logic                   rf_we;
        logic [`REG_AW-1:0]     rf_waddr;
    } ex_pkt_t;

endpackage

`default_nettype wire

/* design/id_decoder.sv */
`default_nettype none

`include "id_config.svh"

module id_decoder (
    input  wire [`ILEN-1:0]       inst,
    output loong_isa_pkg::decode_t dec
);

    import loong_isa_pkg::*;

    // operand/immediate format class
    typedef enum logic [3:0] {
        F_NONE,
        F_3R,
        F_SI12,     // also slli/srli/srai, low 5 bits are ui5
        F_UI12,
        F_ST,
        F_LU12I,
        F_PCADD,
        F_BCOND,
        F_B,
        F_BL,
        F_JIRL
    } fmt_e;

    typedef struct packed {
        alu_op_e  alu;
        mem_op_e  mem;
        br_cond_e br;
        fmt_e     fmt;
    } op_sel_t;

    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] rj;
    logic [`REG_AW-1:0] rk;
    logic [11:0]        i12;
    logic [15:0]        i16;
    logic [19:0]        i20;
    logic [25:0]        i26;
    op_sel_t            sel;

    assign rd  = inst[`RD_LSB +: `REG_AW];
    assign rj  = inst[`RJ_LSB +: `REG_AW];
    assign rk  = inst[`RK_LSB +: `REG_AW];
    assign i12 = inst[`I12_LSB +: 12];
    assign i16 = inst[`I16_LSB +: 16];
    assign i20 = inst[`I20_LSB +: 20];
    assign i26 = {inst[`I26_LSB +: 10], inst[`I16_LSB +: 16]};

    always_comb begin
        casez (inst[`ILEN-1:`OPC_LSB])
            17'h00020:               sel = '{ALU_ADD,  MEM_NONE,  BR_NONE,   F_3R};
            17'h00022:               sel = '{ALU_SUB,  MEM_NONE,  BR_NONE,   F_3R};
            17'h00024:               sel = '{ALU_SLT,  MEM_NONE,  BR_NONE,   F_3R};
            17'h00025:               sel = '{ALU_SLTU, MEM_NONE,  BR_NONE,   F_3R};
            17'h00028:               sel = '{ALU_NOR,  MEM_NONE,  BR_NONE,   F_3R};
            17'h00029:               sel = '{ALU_AND,  MEM_NONE,  BR_NONE,   F_3R};
            17'h0002a:               sel = '{ALU_OR,   MEM_NONE,  BR_NONE,   F_3R};
            17'h0002b:               sel = '{ALU_XOR,  MEM_NONE,  BR_NONE,   F_3R};
            17'h0002e:               sel = '{ALU_SLL,  MEM_NONE,  BR_NONE,   F_3R};
            17'h0002f:               sel = '{ALU_SRL,  MEM_NONE,  BR_NONE,   F_3R};
            17'h00030:               sel = '{ALU_SRA,  MEM_NONE,  BR_NONE,   F_3R};
            17'h00081:               sel = '{ALU_SLL,  MEM_NONE,  BR_NONE,   F_SI12};
            17'h00089:               sel = '{ALU_SRL,  MEM_NONE,  BR_NONE,   F_SI12};
            17'h00091:               sel = '{ALU_SRA,  MEM_NONE,  BR_NONE,   F_SI12};
            {10'h008, 7'b???????}:   sel = '{ALU_SLT,  MEM_NONE,  BR_NONE,   F_SI12};
            {10'h009, 7'b???????}:   sel = '{ALU_SLTU, MEM_NONE,  BR_NONE,   F_SI12};
            {10'h00a, 7'b???????}:   sel = '{ALU_ADD,  MEM_NONE,  BR_NONE,   F_SI12};
            {10'h00d, 7'b???????}:   sel = '{ALU_AND,  MEM_NONE,  BR_NONE,   F_UI12};
            {10'h00e, 7'b???????}:   sel = '{ALU_OR,   MEM_NONE,  BR_NONE,   F_UI12};
            {10'h00f, 7'b???????}:   sel = '{ALU_XOR,  MEM_NONE,  BR_NONE,   F_UI12};
            {10'h0a0, 7'b???????}:   sel = '{ALU_ADD,  MEM_LD_B,  BR_NONE,   F_SI12};
            {10'h0a1, 7'b???????}:   sel = '{ALU_ADD,  MEM_LD_H,  BR_NONE,   F_SI12};
            {10'h0a2, 7'b???????}:   sel = '{ALU_ADD,  MEM_LD_W,  BR_NONE,   F_SI12};
            {10'h0a8, 7'b???????}:   sel = '{ALU_ADD,  MEM_LD_BU, BR_NONE,   F_SI12};
            {10'h0a9, 7'b???????}:   sel = '{ALU_ADD,  MEM_LD_HU, BR_NONE,   F_SI12};
            {10'h0a4, 7'b???????}:   sel = '{ALU_ADD,  MEM_ST_B,  BR_NONE,   F_ST};
            {10'h0a5, 7'b???????}:   sel = '{ALU_ADD,  MEM_ST_H,  BR_NONE,   F_ST};
            {10'h0a6, 7'b???????}:   sel = '{ALU_ADD,  MEM_ST_W,  BR_NONE,   F_ST};
            {7'h0a, 10'b??????????}: sel = '{ALU_LUI,  MEM_NONE,  BR_NONE,   F_LU12I};
            {7'h0e, 10'b??????????}: sel = '{ALU_ADD,  MEM_NONE,  BR_NONE,   F_PCADD};
            {6'h13, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_JIRL,   F_JIRL};
            {6'h14, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_ALWAYS, F_B};
            {6'h15, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_ALWAYS, F_BL};
            {6'h16, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_EQ,     F_BCOND};
            {6'h17, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_NE,     F_BCOND};
            {6'h18, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_LT,     F_BCOND};
            {6'h19, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_GE,     F_BCOND};
            {6'h1a, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_LTU,    F_BCOND};
            {6'h1b, 11'b???????????}: sel = '{ALU_ADD, MEM_NONE,  BR_GEU,    F_BCOND};
            default:                 sel = '{ALU_ADD,  MEM_NONE,  BR_NONE,   F_NONE};
        endcase
    end

    always_comb begin
        dec.alu_op      = sel.alu;
        dec.mem_op      = sel.mem;
        dec.br_cond     = sel.br;
        dec.src1_is_pc  = sel.fmt inside {F_PCADD, F_BL, F_JIRL};
        dec.src2_is_imm = sel.fmt inside {F_SI12, F_UI12, F_ST, F_LU12I, F_PCADD, F_BL, F_JIRL};

        case (sel.fmt)
            F_UI12:          dec.imm = {{(`XLEN-12){1'b0}}, i12};
            F_LU12I, F_PCADD: dec.imm = {i20, 12'b0};
            F_BL, F_JIRL:    dec.imm = `XLEN'(4);  // link value pc+4
            default:         dec.imm = {{(`XLEN-12){i12[11]}}, i12};
        endcase

        if (sel.fmt inside {F_B, F_BL}) begin
            dec.br_offs = {{(`XLEN-28){i26[25]}}, i26, 2'b00};
        end else begin
            dec.br_offs = {{(`XLEN-18){i16[15]}}, i16, 2'b00};
        end

        // stores and compare branches read rd on port 2
        dec.raddr1   = rj;
        dec.raddr2   = (sel.fmt inside {F_ST, F_BCOND}) ? rd : rk;
        dec.need_r1  = sel.fmt inside {F_3R, F_SI12, F_UI12, F_ST, F_BCOND, F_JIRL};
        dec.need_r2  = sel.fmt inside {F_3R, F_ST, F_BCOND};
        dec.rf_we    = sel.fmt inside {F_3R, F_SI12, F_UI12, F_LU12I, F_PCADD, F_BL, F_JIRL};
        dec.rf_waddr = (sel.fmt == F_BL) ? `REG_AW'(1) : rd;   // bl links to r1
    end

endmodule

`default_nettype wire

/* design/id_hazard_unit.sv */
`default_nettype none

`include "id_config.svh"

module id_hazard_unit (
    input  wire                          clk,
    input  wire loong_isa_pkg::decode_t  dec,
    input  wire id_bus_pkg::fwd_t        ex_fwd,
    input  wire id_bus_pkg::fwd_t        mem_fwd,
    input  wire id_bus_pkg::fwd_t        wb_fwd,
    output logic [`XLEN-1:0]             rj_value,
    output logic [`XLEN-1:0]             rkd_value,
    output logic                         stall
);

    import id_bus_pkg::*;

    logic [`XLEN-1:0] rf_rdata1;
    logic [`XLEN-1:0] rf_rdata2;
    logic             r1_stall;
    logic             r2_stall;

    function automatic logic hit(
        input fwd_t               src,
        input logic [`REG_AW-1:0] raddr,
        input logic               need
    );
        return need && (raddr != '0) && src.we && (src.waddr == raddr);
    endfunction

    // newest writer wins, result is {stall, value}
    function automatic logic [`XLEN:0] fwd_select(
        input logic [`REG_AW-1:0] raddr,
        input logic               need,
        input logic [`XLEN-1:0]   rf_data,
        input fwd_t               ex_src,
        input fwd_t               mem_src,
        input fwd_t               wb_src
    );
        if (hit(ex_src, raddr, need)) begin
            return {ex_src.not_ready, ex_src.wdata};
        end
        if (hit(mem_src, raddr, need)) begin
            return {mem_src.not_ready, mem_src.wdata};
        end
        if (hit(wb_src, raddr, need)) begin
            return {1'b0, wb_src.wdata};    // WB data is always final
        end
        return {1'b0, rf_data};
    endfunction

    id_regfile u_regfile (
        .clk    (clk),
        .we     (wb_fwd.we),
        .waddr  (wb_fwd.waddr),
        .wdata  (wb_fwd.wdata),
        .raddr1 (dec.raddr1),
        .raddr2 (dec.raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    assign {r1_stall, rj_value} =
        fwd_select(dec.raddr1, dec.need_r1, rf_rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign {r2_stall, rkd_value} =
        fwd_select(dec.raddr2, dec.need_r2, rf_rdata2, ex_fwd, mem_fwd, wb_fwd);

    assign stall = r1_stall | r2_stall;

endmodule

`default_nettype wire

/* design/id_inst_latch.sv */
`default_nettype none

`include "id_config.svh"

module id_inst_latch (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         if_valid,
    input  wire id_bus_pkg::fetch_pkt_t fetch_pkt,
    input  wire                         ex_allowin,
    input  wire                         stall,
    input  wire                         br_taken,
    output logic                        id_valid,
    output logic                        id_allowin,
    output logic [`ILEN-1:0]            inst,
    output logic [`XLEN-1:0]            pc
);

    logic leave;    // held instruction moves on to EX this cycle

    assign leave      = ~stall & ex_allowin;
    assign id_allowin = ~id_valid | leave;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken && leave) begin
            id_valid <= 1'b0;       // drops the wrong-path fetch taken on this edge
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    // instruction and pc of the held fetch
    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            inst <= fetch_pkt.inst;
            pc   <= fetch_pkt.pc;
        end
    end

endmodule

`default_nettype wire

/* design/id_regfile.sv */
`default_nettype none

`include "id_config.svh"

module id_regfile (
    input  wire                clk,
    input  wire                we,
    input  wire [`REG_AW-1:0]  waddr,
    input  wire [`XLEN-1:0]    wdata,
    input  wire [`REG_AW-1:0]  raddr1,
    input  wire [`REG_AW-1:0]  raddr2,
    output logic [`XLEN-1:0]   rdata1,
    output logic [`XLEN-1:0]   rdata2
);

    logic [`XLEN-1:0] regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* design/id_resolve.sv */
`default_nettype none

`include "id_config.svh"

module id_resolve (
    input  wire loong_isa_pkg::decode_t dec,
    input  wire                         id_valid,
    input  wire [`XLEN-1:0]             pc,
    input  wire [`XLEN-1:0]             rj_value,
    input  wire [`XLEN-1:0]             rkd_value,
    output id_bus_pkg::br_req_t         br_req,
    output id_bus_pkg::ex_pkt_t         ex_pkt
);

    import loong_isa_pkg::*;

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq  = (rj_value == rkd_value);
    assign lt  = ($signed(rj_value) < $signed(rkd_value));
    assign ltu = (rj_value < rkd_value);

    always_comb begin
        case (dec.br_cond)
            BR_EQ:              cond = eq;
            BR_NE:              cond = ~eq;
            BR_LT:              cond = lt;
            BR_GE:              cond = ~lt;
            BR_LTU:             cond = ltu;
            BR_GEU:             cond = ~ltu;
            BR_ALWAYS, BR_JIRL: cond = 1'b1;
            default:            cond = 1'b0;
        endcase
    end

    always_comb begin
        br_req.taken  = cond & id_valid;
        br_req.target = (dec.br_cond == BR_JIRL) ? rj_value + dec.br_offs  // register indirect
                                                 : pc + dec.br_offs;
    end

    always_comb begin
        ex_pkt.alu_op    = dec.alu_op;
        ex_pkt.mem_op    = id_valid ? dec.mem_op : MEM_NONE;   // no stray access from a bubble
        ex_pkt.src1      = dec.src1_is_pc ? pc : rj_value;
        ex_pkt.src2      = dec.src2_is_imm ? dec.imm : rkd_value;
        ex_pkt.rkd_value = rkd_value;
        ex_pkt.pc        = pc;
        ex_pkt.rf_we     = dec.rf_we & id_valid;
        ex_pkt.rf_waddr  = dec.rf_waddr;
    end

endmodule

`default_nettype wire

/* design/id_stage.sv */
`default_nettype none

`include "id_config.svh"

module id_stage (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         if_valid,
    input  wire id_bus_pkg::fetch_pkt_t fetch_pkt,
    output logic                        id_allowin,
    output id_bus_pkg::br_req_t         br_req,
    input  wire                         ex_allowin,
    output logic                        id_to_ex_valid,
    output id_bus_pkg::ex_pkt_t         ex_pkt,
    input  wire id_bus_pkg::fwd_t       ex_fwd,
    input  wire id_bus_pkg::fwd_t       mem_fwd,
    input  wire id_bus_pkg::fwd_t       wb_fwd
);

    import loong_isa_pkg::*;

    logic             id_valid;
    logic             stall;
    logic             id_go;        // valid and operands all available
    logic [`ILEN-1:0] inst;
    logic [`XLEN-1:0] pc;
    decode_t          dec;
    logic [`XLEN-1:0] rj_value;
    logic [`XLEN-1:0] rkd_value;

    id_inst_latch u_latch (
        .clk        (clk),
        .resetn     (resetn),
        .if_valid   (if_valid),
        .fetch_pkt  (fetch_pkt),
        .ex_allowin (ex_allowin),
        .stall      (stall),
        .br_taken   (br_req.taken),
        .id_valid   (id_valid),
        .id_allowin (id_allowin),
        .inst       (inst),
        .pc         (pc)
    );

    id_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    id_hazard_unit u_hazard (
        .clk       (clk),
        .dec       (dec),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    // a stalled branch sees stale operands, so it must not redirect yet
    assign id_go          = id_valid & ~stall;
    assign id_to_ex_valid = id_go;

    id_resolve u_resolve (
        .dec       (dec),
        .id_valid  (id_go),
        .pc        (pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_req    (br_req),
        .ex_pkt    (ex_pkt)
    );

endmodule

`default_nettype wire

/* design/loong_isa_pkg.sv */
`default_nettype none

`include "id_config.svh"

package loong_isa_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LD_B,
        MEM_LD_H,
        MEM_LD_W,
        MEM_LD_BU,
        MEM_LD_HU,
        MEM_ST_B,
        MEM_ST_H,
        MEM_ST_W
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS,  // b, bl
        BR_JIRL
    } br_cond_e;

    typedef struct packed {
        alu_op_e              alu_op;
        mem_op_e              mem_op;
        br_cond_e             br_cond;
        logic                 src1_is_pc;
        logic                 src2_is_imm;
        logic [`XLEN-1:0]     imm;       // 4 for bl / jirl link
        logic [`XLEN-1:0]     br_offs;   // already <<2 and sign extended
        logic [`REG_AW-1:0]   raddr1;
        logic [`REG_AW-1:0]   raddr2;
        logic                 need_r1;
        logic                 need_r2;
        logic                 rf_we;
        logic [`REG_AW-1:0]   rf_waddr;
    } decode_t;

endpackage

`default_nettype wire

/* id_decode.f */
+incdir+include
design/loong_isa_pkg.sv
design/id_bus_pkg.sv
design/id_regfile.sv
design/id_inst_latch.sv
design/id_decoder.sv
design/id_hazard_unit.sv
design/id_resolve.sv
design/id_stage.sv
verif/id_stage_tb.sv

/* include/id_config.svh */
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// datapath widths, fixed by the ISA
`define XLEN    32
`define ILEN    32
`define REG_AW  5
`define REG_NUM 32

// opcode window inst[31:15]
`define OPC_LSB 15

// register fields
`define RD_LSB  0
`define RJ_LSB  5
`define RK_LSB  10

// immediate fields
`define I12_LSB 10
`define I16_LSB 10
`define I20_LSB 5
`define I26_LSB 0   // offs[25:16] sit in inst[9:0]

`endif

/* verif/id_stage_tb.sv */
`default_nettype none

`include "id_config.svh"

module id_stage_tb;

    import loong_isa_pkg::*;
    import id_bus_pkg::*;

    // LoongArch32 base opcodes grouped by field width
    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_SRA_W  = 17'h00030;
    localparam logic [16:0] OP_SLLI_W = 17'h00081;
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_ANDI   = 10'h00d;
    localparam logic [9:0]  OP_LD_B   = 10'h0a0;
    localparam logic [9:0]  OP_LD_HU  = 10'h0a9;
    localparam logic [9:0]  OP_ST_H   = 10'h0a5;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;
    localparam logic [6:0]  OP_LU12I  = 7'h0a;
    localparam logic [6:0]  OP_PCADDU = 7'h0e;
    localparam logic [5:0]  OP_JIRL   = 6'h13;
    localparam logic [5:0]  OP_BL     = 6'h15;
    localparam logic [5:0]  OP_BEQ    = 6'h16;
    localparam logic [5:0]  OP_BLTU   = 6'h1a;

    logic       clk;
    logic       resetn;
    logic       if_valid;
    fetch_pkt_t fetch_pkt;
    logic       id_allowin;
    br_req_t    br_req;
    logic       ex_allowin;
    logic       id_to_ex_valid;
    ex_pkt_t    ex_pkt;
    fwd_t       ex_fwd;
    fwd_t       mem_fwd;
    fwd_t       wb_fwd;

    logic [`XLEN-1:0] model [`REG_NUM];    // expected architectural registers
    logic [31:0]      lfsr;
    logic [`XLEN-1:0] pc_ctr;              // pc of the next fetch
    logic [`XLEN-1:0] cur_pc;              // pc of the last accepted fetch
    int               errors;
    int               checks;

    id_stage id_stage_inst (
        .clk            (clk),
        .resetn         (resetn),
        .if_valid       (if_valid),
        .fetch_pkt      (fetch_pkt),
        .id_allowin     (id_allowin),
        .br_req         (br_req),
        .ex_allowin     (ex_allowin),
        .id_to_ex_valid (id_to_ex_valid),
        .ex_pkt         (ex_pkt),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w    = {w[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);     // one step per bit
        end
        return w;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [11:0] i12,
                                             input logic [4:0] rj, input logic [4:0] rd);
        return {op, i12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri20(input logic [6:0] op, input logic [19:0] i20,
                                             input logic [4:0] rd);
        return {op, i20, rd};
    endfunction

    function automatic logic [31:0] enc_ri16(input logic [5:0] op, input logic [15:0] i16,
                                             input logic [4:0] rj, input logic [4:0] rd);
        return {op, i16, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};   // high offset bits go low
    endfunction

    function automatic fwd_t mk_fwd(input logic we, input logic [4:0] waddr,
                                    input logic [31:0] wdata, input logic not_ready);
        return '{we: we, waddr: waddr, wdata: wdata, not_ready: not_ready};
    endfunction

    task automatic check(input string name, input logic [159:0] got, input logic [159:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_fwd();
        ex_fwd  = '0;
        mem_fwd = '0;
        wb_fwd  = '0;
    endtask

    task automatic preload_reg(input logic [4:0] addr, input logic [31:0] data);
        step();
        wb_fwd = mk_fwd(1'b1, addr, data, 1'b0);
        step();                         // write lands on this edge
        wb_fwd = '0;
        model[addr] = data;
    endtask

    // offers one fetch and returns one unit after the edge that took it
    task automatic issue(input logic [31:0] inst);
        int waited;
        step();
        fetch_pkt = '{inst: inst, pc: pc_ctr};
        if_valid  = 1'b1;
        waited    = 0;
        while (!id_allowin && waited < 20) begin
            step();
            waited++;
        end
        if (!id_allowin) begin
            errors++;
            $display("timed out waiting for id_allowin with fetch at pc %h", pc_ctr);
        end
        step();
        if_valid = 1'b0;
        cur_pc   = pc_ctr;
        pc_ctr   = pc_ctr + 4;
    endtask

    task automatic expect_ex(input alu_op_e alu, input logic [31:0] src1,
                             input logic [31:0] src2, input logic we, input logic [4:0] waddr);
        check("id_to_ex_valid", id_to_ex_valid, 1'b1);
        check("ex_pkt.alu_op", ex_pkt.alu_op, alu);
        check("ex_pkt.src1", ex_pkt.src1, src1);
        check("ex_pkt.src2", ex_pkt.src2, src2);
        check("ex_pkt.rf_we", ex_pkt.rf_we, we);
        check("ex_pkt.rf_waddr", ex_pkt.rf_waddr, waddr);
    endtask

    task automatic rr_case(input logic [16:0] op, input alu_op_e alu, input logic [4:0] rk,
                           input logic [4:0] rj, input logic [4:0] rd);
        issue(enc_3r(op, rk, rj, rd));
        #2;
        expect_ex(alu, model[rj], model[rk], 1'b1, rd);
    endtask

    task automatic test_alu_imm();
        issue(enc_ri12(OP_ADDI_W, 12'hf9c, 2, 10));     // -100
        #2;
        expect_ex(ALU_ADD, model[2], 32'hffff_ff9c, 1'b1, 10);
        issue(enc_ri12(OP_ANDI, 12'hf0f, 3, 11));
        #2;
        expect_ex(ALU_AND, model[3], 32'h0000_0f0f, 1'b1, 11);
        issue(enc_ri20(OP_LU12I, 20'habcde, 12));
        #2;
        check("ex_pkt.alu_op", ex_pkt.alu_op, ALU_LUI);
        check("ex_pkt.src2", ex_pkt.src2, 32'habcd_e000);
        check("ex_pkt.rf_we", ex_pkt.rf_we, 1'b1);
        check("ex_pkt.rf_waddr", ex_pkt.rf_waddr, 5'd12);
        issue(enc_3r(OP_SLLI_W, 5'd7, 4, 13));
        #2;
        check("ex_pkt.alu_op", ex_pkt.alu_op, ALU_SLL);
        check("ex_pkt.src1", ex_pkt.src1, model[4]);
        check("ex_pkt.src2 shamt", ex_pkt.src2[4:0], 5'd7);   // EX shifts by the low 5 bits
        check("ex_pkt.rf_we", ex_pkt.rf_we, 1'b1);
        issue(enc_ri20(OP_PCADDU, 20'h00012, 14));
        #2;
        expect_ex(ALU_ADD, cur_pc, 32'h0001_2000, 1'b1, 14);
    endtask

    task automatic fwd_case(input logic ex_on, input logic mem_on);
        logic [31:0] ex_d;
        logic [31:0] mem_d;
        logic [31:0] wb_d;
        ex_d  = rand_word();
        mem_d = rand_word();
        wb_d  = rand_word();
        issue(enc_3r(OP_ADD_W, 6, 5, 15));
        ex_fwd  = mk_fwd(ex_on, 5, ex_d, 1'b0);
        mem_fwd = mk_fwd(mem_on, 5, mem_d, 1'b0);
        wb_fwd  = mk_fwd(1'b1, 5, wb_d, 1'b0);
        #2;
        check("ex_pkt.src1 fwd", ex_pkt.src1, ex_on ? ex_d : (mem_on ? mem_d : wb_d));
        check("ex_pkt.src2", ex_pkt.src2, model[6]);
        step();
        clear_fwd();
        model[5] = wb_d;
    endtask

    task automatic test_forwarding();
        fwd_case(1'b0, 1'b0);
        fwd_case(1'b0, 1'b1);
        fwd_case(1'b1, 1'b1);
        issue(enc_3r(OP_ADD_W, 6, 0, 15));              // rj is r0
        ex_fwd  = mk_fwd(1'b1, 0, rand_word(), 1'b1);
        mem_fwd = mk_fwd(1'b1, 0, rand_word(), 1'b0);
        wb_fwd  = mk_fwd(1'b1, 0, rand_word(), 1'b0);
        #2;
        check("ex_pkt.src1 r0", ex_pkt.src1, 32'h0);
        check("id_to_ex_valid r0", id_to_ex_valid, 1'b1);
        step();
        clear_fwd();
    endtask

    task automatic test_stall();
        logic [31:0] v;
        ex_pkt_t     held;
        v      = rand_word();
        ex_fwd = mk_fwd(1'b1, 7, v, 1'b1);             // load still in flight
        issue(enc_3r(OP_ADD_W, 8, 7, 16));
        for (int i = 0; i < 3; i++) begin
            #2;
            check("id_to_ex_valid stall", id_to_ex_valid, 1'b0);
            check("id_allowin stall", id_allowin, 1'b0);
            step();
        end
        ex_fwd.not_ready = 1'b0;
        #2;
        check("id_to_ex_valid release", id_to_ex_valid, 1'b1);
        check("ex_pkt.src1 release", ex_pkt.src1, v);
        step();
        clear_fwd();
        ex_allowin = 1'b0;
        issue(enc_3r(OP_SUB_W, 3, 2, 17));
        fetch_pkt = '{inst: enc_3r(OP_ADD_W, 9, 8, 18), pc: pc_ctr};   // must wait in IF
        if_valid  = 1'b1;
        #2;
        check("id_to_ex_valid hold", id_to_ex_valid, 1'b1);
        check("id_allowin hold", id_allowin, 1'b0);
        held = ex_pkt;
        repeat (3) begin
            step();
            #2;
            check("ex_pkt hold", ex_pkt, held);
            check("id_allowin hold", id_allowin, 1'b0);
        end
        step();
        ex_allowin = 1'b1;
        if_valid   = 1'b0;
        #2;
        check("id_allowin after hold", id_allowin, 1'b1);
    endtask

    task automatic branch_case(input logic [31:0] inst, input logic taken,
                               input logic [31:0] target, input logic link,
                               input logic [4:0] link_reg);
        issue(inst);
        fetch_pkt = '{inst: enc_3r(OP_ADD_W, 0, 0, 0), pc: pc_ctr};   // fall-through fetch
        if_valid  = 1'b1;
        #2;
        check("br_req.taken", br_req.taken, taken);
        check("br_req.target", br_req.target, target);
        check("id_to_ex_valid branch", id_to_ex_valid, 1'b1);
        if (link) begin
            check("ex_pkt.rf_we link", ex_pkt.rf_we, 1'b1);
            check("ex_pkt.rf_waddr link", ex_pkt.rf_waddr, link_reg);
            check("ex_pkt.src1 link", ex_pkt.src1, cur_pc);
            check("ex_pkt.src2 link", ex_pkt.src2, 32'd4);
        end
        step();
        if_valid = 1'b0;
        #2;
        check("id_to_ex_valid after branch", id_to_ex_valid, !taken);
        if (!taken) begin
            check("ex_pkt.pc fall-through", ex_pkt.pc, pc_ctr);
        end
        pc_ctr = pc_ctr + 4;
    endtask

    task automatic test_branches();
        branch_case(enc_ri16(OP_BEQ, 16'h0010, 20, 20), 1'b1, pc_ctr + 32'h40, 1'b0, 0);
        branch_case(enc_ri16(OP_BEQ, 16'hfff0, 20, 21), 1'b0, pc_ctr - 32'h40, 1'b0, 0);
        branch_case(enc_ri16(OP_BLTU, 16'h0004, 21, 20), 1'b1, pc_ctr + 32'h10, 1'b0, 0);
        branch_case(enc_ri16(OP_BLTU, 16'h0004, 20, 21), 1'b0, pc_ctr + 32'h10, 1'b0, 0);
        branch_case(enc_i26(OP_BL, 26'h000_0100), 1'b1, pc_ctr + 32'h400, 1'b1, 1);
        branch_case(enc_ri16(OP_JIRL, 16'h0008, 2, 17), 1'b1, model[2] + 32'h20, 1'b1, 17);
    endtask

    task automatic mem_case(input logic [31:0] inst, input mem_op_e mem, input logic we,
                            input logic [31:0] src2, input logic [31:0] rkd);
        issue(inst);
        #2;
        check("ex_pkt.mem_op", ex_pkt.mem_op, mem);
        check("ex_pkt.rf_we", ex_pkt.rf_we, we);
        check("ex_pkt.src2", ex_pkt.src2, src2);
        if (!we) begin
            check("ex_pkt.rkd_value", ex_pkt.rkd_value, rkd);   // store data from rd
        end
    endtask

    initial begin
        resetn     = 1'b0;
        if_valid   = 1'b0;
        fetch_pkt  = '0;
        ex_allowin = 1'b1;
        clear_fwd();
        lfsr   = 32'd12;
        pc_ctr = 32'h1c00_0000;
        cur_pc = '0;
        errors = 0;
        checks = 0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        #2;
        check("id_to_ex_valid reset", id_to_ex_valid, 1'b0);
        check("br_req.taken reset", br_req.taken, 1'b0);
        check("id_allowin reset", id_allowin, 1'b1);

        for (int r = 2; r <= 9; r++) begin
            preload_reg(r, rand_word());
        end
        preload_reg(20, 32'h8000_0000);
        preload_reg(21, 32'h0000_0001);

        rr_case(OP_ADD_W, ALU_ADD, 3, 2, 10);
        rr_case(OP_SUB_W, ALU_SUB, 5, 4, 11);
        rr_case(OP_SLT, ALU_SLT, 7, 6, 12);
        rr_case(OP_NOR, ALU_NOR, 9, 8, 13);
        rr_case(OP_SRA_W, ALU_SRA, 2, 9, 14);
        test_alu_imm();
        test_forwarding();
        test_stall();
        test_branches();
        mem_case(enc_ri12(OP_LD_B, 12'h010, 2, 18), MEM_LD_B, 1'b1, 32'h10, 0);
        mem_case(enc_ri12(OP_LD_HU, 12'hffc, 3, 19), MEM_LD_HU, 1'b1, 32'hffff_fffc, 0);
        mem_case(enc_ri12(OP_ST_H, 12'h008, 2, 4), MEM_ST_H, 1'b0, 32'h8, model[4]);
        mem_case(enc_ri12(OP_ST_W, 12'h000, 3, 5), MEM_ST_W, 1'b0, 32'h0, model[5]);
        step();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
